// ==== all.f ====
common/par_pkg.sv
src/iter_dispenser.sv
worker/par_worker.sv
src/acc_reduce.sv
src/par_cluster.sv
verification/par_cluster_assert.sv
verification/par_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module par_cluster_tb -o sim_par_cluster
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_par_cluster > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== verification/par_cluster_tb.sv ====
module par_cluster_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {HOLD_NONE, HOLD_RANDOM, HOLD_HEAVY} hold_mode_e;

	// One table row, a second command restarts the loop mid-run
	typedef struct {
		par_pkg::fork_cmd_t cmd;
		hold_mode_e mode;
		logic restart;
		par_pkg::fork_cmd_t cmd2;
	} case_t;

	logic clk = 1'b0;
	logic rst_n;
	logic do_fork;
	par_pkg::fork_cmd_t cmd;
	logic [par_pkg::N_CORE-1:0] hold;
	logic done;
	par_pkg::result_t result;

	logic [31:0] lfsr_state;
	int errors;
	case_t cases [9];

	par_cluster DUT (
		.clk(clk),
		.rst_n(rst_n),
		.do_fork(do_fork),
		.cmd(cmd),
		.hold(hold),
		.done(done),
		.result(result)
	);

	always #4 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function logic take_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// Heavy mode holds a core about three cycles out of four
	function logic [par_pkg::N_CORE-1:0] hold_bits(input hold_mode_e mode);
		logic [par_pkg::N_CORE-1:0] h;
		h = '0;
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			if (mode == HOLD_RANDOM) begin
				h[i] = take_bit();
			end else if (mode == HOLD_HEAVY) begin
				h[i] = take_bit() | take_bit();
			end
		end
		return h;
	endfunction

	function automatic par_pkg::fork_cmd_t make_cmd(input int start, input int step,
			input int bound, input int coeff);
		par_pkg::fork_cmd_t c;
		c.start = start;
		c.step = step;
		c.bound = bound;
		c.coeff = coeff;
		return c;
	endfunction

	// Walks the whole range, independent of which core drew which index
	function automatic par_pkg::result_t model_loop(input par_pkg::fork_cmd_t c);
		par_pkg::result_t r;
		logic signed [par_pkg::DATA_W-1:0] idx;
		logic signed [par_pkg::DATA_W-1:0] bound;
		logic neg;
		int n;
		r = '0;
		idx = c.start;
		bound = c.bound;
		neg = c.step[par_pkg::DATA_W-1];
		n = 0;
		while ((neg ? (idx > bound) : (idx < bound)) && n < 65536) begin
			r.sum = r.sum + idx * c.coeff;
			r.count = r.count + par_pkg::CNT_W'(1);
			idx = idx + c.step;
			n++;
		end
		return r;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compare_result(input par_pkg::result_t got, input par_pkg::result_t exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got sum %0d count %0d, expected sum %0d count %0d",
				$time, what, got.sum, got.count, exp.sum, exp.count);
			fail_now("result differs from the reference loop");
		end
	endtask

	task automatic set_case(input int k, input par_pkg::fork_cmd_t c, input hold_mode_e m,
			input logic r, input par_pkg::fork_cmd_t c2);
		cases[k].cmd = c;
		cases[k].mode = m;
		cases[k].restart = r;
		cases[k].cmd2 = c2;
	endtask

	// Fork is a single-cycle pulse
	task automatic drive_fork(input par_pkg::fork_cmd_t c, input hold_mode_e mode);
		@(posedge clk);
		do_fork <= 1'b1;
		cmd <= c;
		hold <= hold_bits(mode);
		@(posedge clk);
		do_fork <= 1'b0;
		hold <= hold_bits(mode);
	endtask

	task automatic expect_quiet(input int cycles, input hold_mode_e mode, input string why);
		for (int n = 0; n < cycles; n++) begin
			@(posedge clk);
			hold <= hold_bits(mode);
			@(negedge clk);
			if (done) begin
				fail_now(why);
			end
		end
	endtask

	task automatic wait_done(input hold_mode_e mode, input int limit,
			output par_pkg::result_t got);
		logic found;
		int n;
		found = 1'b0;
		n = 0;
		got = '0;
		while (!found && n < limit) begin
			@(posedge clk);
			hold <= hold_bits(mode);
			@(negedge clk);
			if (done) begin
				found = 1'b1;
				got = result;
			end
			n++;
		end
		if (!found) begin
			fail_now("timed out waiting for done");
		end
	endtask

	initial begin
		par_pkg::result_t got;
		par_pkg::result_t exp;
		par_pkg::fork_cmd_t last;
		rst_n <= 1'b0;
		do_fork <= 1'b0;
		cmd <= '0;
		hold <= '0;
		lfsr_state = 32'h4ec1_8584;
		errors = 0;

		set_case(0, make_cmd(3, 2, 41, 5), HOLD_NONE, 1'b0, '0);
		set_case(1, make_cmd(10, -3, -20, -7), HOLD_NONE, 1'b0, '0);
		set_case(2, make_cmd(3, 2, 41, 5), HOLD_RANDOM, 1'b0, '0);
		set_case(3, make_cmd(10, -3, -20, -7), HOLD_RANDOM, 1'b0, '0);
		set_case(4, make_cmd(-50, 7, 300, 3), HOLD_RANDOM, 1'b0, '0);
		set_case(5, make_cmd(100, -1, 0, 2), HOLD_HEAVY, 1'b0, '0);
		set_case(6, make_cmd(5, 1, 5, 9), HOLD_NONE, 1'b0, '0);
		set_case(7, make_cmd(20, 4, 10, 1), HOLD_RANDOM, 1'b0, '0);
		set_case(8, make_cmd(0, 1, 1000, 1), HOLD_RANDOM, 1'b1, make_cmd(7, 3, 200, -2));

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		expect_quiet(20, HOLD_NONE, "done went high after reset without a fork");

		for (int k = 0; k < $size(cases); k++) begin
			drive_fork(cases[k].cmd, cases[k].mode);
			last = cases[k].cmd;
			if (cases[k].restart) begin
				// First loop is long, so it must not finish before the restart
				expect_quiet(12, cases[k].mode, "done went high before the restart fork");
				drive_fork(cases[k].cmd2, cases[k].mode);
				last = cases[k].cmd2;
			end
			exp = model_loop(last);
			wait_done(cases[k].mode, 4000, got);
			compare_result(got, exp, $sformatf("case %0d", k));
		end

		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== verification/par_cluster_assert.sv ====
module par_cluster_assert (
	input logic clk,
	input logic rst_n,
	input logic do_fork,
	input logic [par_pkg::N_CORE-1:0] req,
	input par_pkg::worker_stat_t stat [par_pkg::N_CORE],
	input logic done
);

	timeunit 1ns;
	timeprecision 1ps;

	logic seen_fork;
	logic [par_pkg::N_CORE-1:0] ending;

	always_comb begin
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			ending[i] = stat[i].ending;
		end
	end

	// Sticky once the first loop has been started
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen_fork <= 1'b0;
		end else if (do_fork) begin
			seen_fork <= 1'b1;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done stayed high for two cycles");

	a_ending_no_req: assert property (@(posedge clk) disable iff (!rst_n) (req & ending) == '0)
		else $error("a worker requested while ending");

	a_no_early_done: assert property (@(posedge clk) disable iff (!rst_n) !seen_fork |-> !done)
		else $error("done rose before any fork");

endmodule

bind par_cluster par_cluster_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.do_fork(do_fork),
	.req(req),
	.stat(stat),
	.done(done)
);

// ==== src/par_cluster.sv ====
module par_cluster (
	input logic clk,
	input logic rst_n,
	input logic do_fork,
	input par_pkg::fork_cmd_t cmd,
	input logic [par_pkg::N_CORE-1:0] hold,
	output logic done,
	output par_pkg::result_t result
);

	// Iteration requests, one bit per worker
	logic [par_pkg::N_CORE-1:0] req;

	// Index offered to each worker in the request cycle
	logic signed [par_pkg::DATA_W-1:0] index [par_pkg::N_CORE];

	// Worker status into the reducer
	par_pkg::worker_stat_t stat [par_pkg::N_CORE];

	// Shared loop counter
	iter_dispenser u_dispenser (
		.clk,
		.rst_n,
		.do_fork,
		.cmd,
		.req,
		.index
	);

	// Peer workers, all identical
	for (genvar i = 0; i < par_pkg::N_CORE; i++) begin : g_worker
		par_worker u_worker (
			.clk,
			.rst_n,
			.do_fork,
			.cmd,
			.hold(hold[i]),
			.req(req[i]),
			.index(index[i]),
			.stat(stat[i])
		);
	end

	// Totals once every worker is ending
	acc_reduce u_reduce (
		.clk,
		.rst_n,
		.do_fork,
		.stat,
		.done,
		.result
	);

endmodule

// ==== src/acc_reduce.sv ====
module acc_reduce (
	input logic clk,
	input logic rst_n,
	input logic do_fork,
	input par_pkg::worker_stat_t stat [par_pkg::N_CORE],
	output logic done,
	output par_pkg::result_t result
);

	// Set by a fork, cleared once the result is out
	logic busy;

	// All workers finished their share
	logic all_ending;

	// Cluster-wide totals
	logic signed [par_pkg::DATA_W-1:0] sum;
	logic [par_pkg::CNT_W-1:0] total;

	// Take the result in this cycle
	logic fire;

	always_comb begin
		all_ending = 1'b1;
		sum = '0;
		total = '0;
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			all_ending = all_ending && stat[i].ending;
			sum = sum + stat[i].acc;
			total = total + stat[i].count;
		end
	end

	// A new fork wins over a loop that happens to finish in the same cycle
	assign fire = busy && all_ending && !do_fork;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (do_fork) begin
			busy <= 1'b1;
		end else if (fire) begin
			busy <= 1'b0;
		end
	end

	// One-cycle pulse, fire is only high once per loop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= fire;
		end
	end

	// Holds until the next loop finishes
	always_ff @(posedge clk) begin
		if (fire) begin
			result.sum <= sum;
			result.count <= total;
		end
	end

endmodule

// ==== worker/par_worker.sv ====
module par_worker (
	input logic clk,
	input logic rst_n,
	input logic do_fork,
	input par_pkg::fork_cmd_t cmd,
	input logic hold,
	output logic req,
	input logic signed [par_pkg::DATA_W-1:0] index,
	output par_pkg::worker_stat_t stat
);

	// Loop parameters captured at fork
	logic signed [par_pkg::DATA_W-1:0] coeff;
	logic signed [par_pkg::DATA_W-1:0] bound;
	logic step_neg;

	// Still drawing indices
	logic run;

	// Range test on the index granted this cycle
	logic in_range;
	logic take;
	logic stop;

	// Multiply stage
	logic mul_vld;
	logic signed [par_pkg::DATA_W-1:0] mul_q;

	// Accumulate stage
	logic signed [par_pkg::DATA_W-1:0] acc;
	logic [par_pkg::CNT_W-1:0] count;

	// Nothing left to draw and nothing in flight
	logic drained;
	logic ending;

	assign req = run && !hold;

	// Direction of the bound follows the sign of step
	always_comb begin
		if (step_neg) begin
			in_range = index > bound;
		end else begin
			in_range = index < bound;
		end
	end

	// Grant arrives with the request
	assign take = req && in_range;
	assign stop = req && !in_range;

	always_ff @(posedge clk) begin
		if (do_fork) begin
			coeff <= cmd.coeff;
			bound <= cmd.bound;
			step_neg <= cmd.step[par_pkg::DATA_W-1];
		end
	end

	// First out-of-range index ends the drawing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
		end else if (do_fork) begin
			run <= 1'b1;
		end else if (stop) begin
			run <= 1'b0;
		end
	end

	// Stage one registers the product of the granted index
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mul_vld <= 1'b0;
		end else begin
			// A fork drops whatever was granted from the old loop
			mul_vld <= take && !do_fork;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			mul_q <= index * coeff;
		end
	end

	// Stage two adds into the running sum
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
			count <= '0;
		end else if (do_fork) begin
			acc <= '0;
			count <= '0;
		end else if (mul_vld) begin
			acc <= acc + mul_q;
			count <= count + par_pkg::CNT_W'(1);
		end
	end

	assign drained = !run && !mul_vld;

	// High out of reset, so an idle worker never blocks the reducer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ending <= 1'b1;
		end else if (do_fork) begin
			ending <= 1'b0;
		end else if (drained) begin
			ending <= 1'b1;
		end
	end

	assign stat.acc = acc;
	assign stat.count = count;
	assign stat.ending = ending;

endmodule

// ==== src/iter_dispenser.sv ====
module iter_dispenser (
	input logic clk,
	input logic rst_n,
	input logic do_fork,
	input par_pkg::fork_cmd_t cmd,
	input logic [par_pkg::N_CORE-1:0] req,
	output logic signed [par_pkg::DATA_W-1:0] index [par_pkg::N_CORE]
);

	// Shared loop counter and the step that came with the fork
	logic signed [par_pkg::DATA_W-1:0] counter;
	logic signed [par_pkg::DATA_W-1:0] step;

	// Candidate indices counter + k * step, for k = 0 .. N_CORE
	logic signed [par_pkg::DATA_W-1:0] plus [par_pkg::N_CORE+1];

	// Requests from cores below each core
	// The last entry is the number of grants in this cycle
	logic [par_pkg::PFX_W-1:0] pfx [par_pkg::N_CORE+1];

	// Counter value after this cycle's grants
	logic signed [par_pkg::DATA_W-1:0] counter_next;

	// Built by repeated addition, no multiplier needed
	always_comb begin
		plus[0] = counter;
		for (int k = 1; k <= par_pkg::N_CORE; k++) begin
			plus[k] = plus[k-1] + step;
		end
	end

	// Running prefix count, lower core index wins the lower offset
	always_comb begin
		pfx[0] = '0;
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			pfx[i+1] = pfx[i] + {{(par_pkg::PFX_W-1){1'b0}}, req[i]};
		end
	end

	// Each requester skips past the ones below it
	// Cores that do not request see a value too, which they ignore
	for (genvar i = 0; i < par_pkg::N_CORE; i++) begin : g_grant
		assign index[i] = plus[pfx[i]];
	end

	assign counter_next = plus[pfx[par_pkg::N_CORE]];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			counter <= '0;
			step <= '0;
		end else if (do_fork) begin
			// A fork restarts the loop, grants of this cycle are dropped
			counter <= cmd.start;
			step <= cmd.step;
		end else begin
			counter <= counter_next;
		end
	end

endmodule

// ==== common/par_pkg.sv ====
package par_pkg;

	// Cluster size
	localparam int N_CORE = 4;

	// Datapath widths
	localparam int DATA_W = 32;
	localparam int CNT_W = 16;

	// Wide enough to count every core requesting in the same cycle
	localparam int PFX_W = $clog2(N_CORE + 1);

	// Loop description carried by a fork
	// The loop runs from start in steps of step and stops before bound.
	// Every index in range contributes index * coeff.
	typedef struct packed {
		logic signed [DATA_W-1:0] start;
		logic signed [DATA_W-1:0] step;
		logic signed [DATA_W-1:0] bound;
		logic signed [DATA_W-1:0] coeff;
	} fork_cmd_t;

	// What one worker reports to the reducer
	typedef struct packed {
		logic signed [DATA_W-1:0] acc;
		logic [CNT_W-1:0] count;
		logic ending;
	} worker_stat_t;

	// Reduced result of a whole loop
	typedef struct packed {
		logic signed [DATA_W-1:0] sum;
		logic [CNT_W-1:0] count;
	} result_t;

endpackage
